/* Makefile */
SRCS := $(shell cat compile.f)

.PHONY: all run clean

all: run

obj_dir/Vexec_cluster_tb: compile.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module exec_cluster_tb -f compile.f

run: obj_dir/Vexec_cluster_tb
	./obj_dir/Vexec_cluster_tb

clean:
	rm -rf obj_dir

/* compile.f */
src/tomasulo_pkg.sv
src/reservation_station.sv
src/issue_queue.sv
src/alu_unit.sv
src/exec_cluster.sv
tests/exec_cluster_sva.sv
tests/exec_cluster_tb.sv

/* src/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,
    input  logic                                head_valid,
    input  logic [tomasulo_pkg::op_width-1:0]   head_op,
    input  logic [tomasulo_pkg::tag_width-1:0]  head_tag,
    input  logic [tomasulo_pkg::data_width-1:0] head_a,
    input  logic [tomasulo_pkg::data_width-1:0] head_b,
    output logic                                pop,
    output logic                                cdb_valid,
    output logic [tomasulo_pkg::tag_width-1:0]  cdb_tag,
    output logic [tomasulo_pkg::data_width-1:0] cdb_value
);
    import tomasulo_pkg::*;

    // operation latched at pop
    logic [op_width-1:0]   ex_op;
    logic [tag_width-1:0]  ex_tag;
    logic [data_width-1:0] ex_a;
    logic [data_width-1:0] ex_b;

    // cycles left until broadcast, 1 means it goes out at the next edge
    logic [mul_cnt_width-1:0] remaining;
    logic                     finishing;

    assign finishing = remaining == mul_cnt_width'(1);

    // a finishing op can be replaced in the same cycle
    assign pop = head_valid && (remaining == '0 || finishing);

    always_ff @(posedge clk) begin
        if (pop) begin
            ex_op <= head_op;
            ex_tag <= head_tag;
            ex_a <= head_a;
            ex_b <= head_b;
        end
        if (finishing) begin
            cdb_tag <= ex_tag;
            cdb_value <= alu_result(ex_op, ex_a, ex_b);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            remaining <= '0;
            cdb_valid <= 1'b0;
        end else if (flush) begin
            // in-flight op is dropped
            remaining <= '0;
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= finishing;
            if (pop) begin
                remaining <= head_op == op_mul ? mul_cnt_width'(mul_cycles)
                                               : mul_cnt_width'(1);
            end else if (remaining != '0) begin
                remaining <= remaining - 1'b1;
            end
        end
    end

endmodule

/* src/exec_cluster.sv */
`timescale 1ns/1ps

module exec_cluster (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,
    input  logic                                disp_valid,
    input  logic [tomasulo_pkg::op_width-1:0]   disp_op,
    input  logic                                disp_use_imm,
    input  logic [tomasulo_pkg::tag_width-1:0]  disp_tag,
    input  logic [tomasulo_pkg::tag_width-1:0]  disp_src1_tag,
    input  logic [tomasulo_pkg::data_width-1:0] disp_src1_val,
    input  logic [tomasulo_pkg::tag_width-1:0]  disp_src2_tag,
    input  logic [tomasulo_pkg::data_width-1:0] disp_src2_val,
    input  logic [tomasulo_pkg::data_width-1:0] disp_imm,
    output logic                                disp_credit,
    output logic                                cdb_valid_0,
    output logic [tomasulo_pkg::tag_width-1:0]  cdb_tag_0,
    output logic [tomasulo_pkg::data_width-1:0] cdb_value_0,
    output logic                                cdb_valid_1,
    output logic [tomasulo_pkg::tag_width-1:0]  cdb_tag_1,
    output logic [tomasulo_pkg::data_width-1:0] cdb_value_1
);
    import tomasulo_pkg::*;

    logic                  issue_valid [2];
    logic [op_width-1:0]   issue_op    [2];
    logic [tag_width-1:0]  issue_tag   [2];
    logic [data_width-1:0] issue_a     [2];
    logic [data_width-1:0] issue_b     [2];
    logic                  iq_credit   [2];

    logic                  head_valid  [2];
    logic [op_width-1:0]   head_op     [2];
    logic [tag_width-1:0]  head_tag    [2];
    logic [data_width-1:0] head_a      [2];
    logic [data_width-1:0] head_b      [2];
    logic                  pop         [2];

    logic                  cdb_valid   [2];
    logic [tag_width-1:0]  cdb_tag     [2];
    logic [data_width-1:0] cdb_value   [2];

    assign cdb_valid_0 = cdb_valid[0];
    assign cdb_tag_0 = cdb_tag[0];
    assign cdb_value_0 = cdb_value[0];
    assign cdb_valid_1 = cdb_valid[1];
    assign cdb_tag_1 = cdb_tag[1];
    assign cdb_value_1 = cdb_value[1];

    // both cdb lanes loop back for wakeup
    reservation_station rs_i (
        .clk, .rst, .flush,
        .disp_valid, .disp_op, .disp_use_imm, .disp_tag,
        .disp_src1_tag, .disp_src1_val, .disp_src2_tag, .disp_src2_val,
        .disp_imm, .disp_credit,
        .cdb_valid_0(cdb_valid[0]), .cdb_tag_0(cdb_tag[0]), .cdb_value_0(cdb_value[0]),
        .cdb_valid_1(cdb_valid[1]), .cdb_tag_1(cdb_tag[1]), .cdb_value_1(cdb_value[1]),
        .issue_valid_0(issue_valid[0]), .issue_op_0(issue_op[0]), .issue_tag_0(issue_tag[0]),
        .issue_a_0(issue_a[0]), .issue_b_0(issue_b[0]), .iq_credit_0(iq_credit[0]),
        .issue_valid_1(issue_valid[1]), .issue_op_1(issue_op[1]), .issue_tag_1(issue_tag[1]),
        .issue_a_1(issue_a[1]), .issue_b_1(issue_b[1]), .iq_credit_1(iq_credit[1])
    );

    for (genvar n = 0; n < 2; n++) begin : g_lane
        issue_queue #(.depth(iq_depth)) iq_i (
            .clk, .rst, .flush,
            .push(issue_valid[n]), .push_op(issue_op[n]), .push_tag(issue_tag[n]),
            .push_a(issue_a[n]), .push_b(issue_b[n]),
            .head_valid(head_valid[n]), .head_op(head_op[n]), .head_tag(head_tag[n]),
            .head_a(head_a[n]), .head_b(head_b[n]),
            .pop(pop[n]), .credit(iq_credit[n])
        );

        alu_unit alu_i (
            .clk, .rst, .flush,
            .head_valid(head_valid[n]), .head_op(head_op[n]), .head_tag(head_tag[n]),
            .head_a(head_a[n]), .head_b(head_b[n]), .pop(pop[n]),
            .cdb_valid(cdb_valid[n]), .cdb_tag(cdb_tag[n]), .cdb_value(cdb_value[n])
        );
    end

endmodule

/* src/issue_queue.sv */
`timescale 1ns/1ps

module issue_queue #(
    parameter int depth = tomasulo_pkg::iq_depth
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,
    input  logic                                push,
    input  logic [tomasulo_pkg::op_width-1:0]   push_op,
    input  logic [tomasulo_pkg::tag_width-1:0]  push_tag,
    input  logic [tomasulo_pkg::data_width-1:0] push_a,
    input  logic [tomasulo_pkg::data_width-1:0] push_b,
    output logic                                head_valid,
    output logic [tomasulo_pkg::op_width-1:0]   head_op,
    output logic [tomasulo_pkg::tag_width-1:0]  head_tag,
    output logic [tomasulo_pkg::data_width-1:0] head_a,
    output logic [tomasulo_pkg::data_width-1:0] head_b,
    input  logic                                pop,
    output logic                                credit
);
    import tomasulo_pkg::*;

    localparam int ptr_width = depth > 1 ? $clog2(depth) : 1;

    logic [op_width-1:0]   mem_op  [depth];
    logic [tag_width-1:0]  mem_tag [depth];
    logic [data_width-1:0] mem_a   [depth];
    logic [data_width-1:0] mem_b   [depth];

    logic [ptr_width-1:0]    wr_ptr;
    logic [ptr_width-1:0]    rd_ptr;
    logic [$clog2(depth+1)-1:0] count;

    function automatic logic [ptr_width-1:0] ptr_inc(input logic [ptr_width-1:0] ptr);
        return ptr == ptr_width'(depth - 1) ? '0 : ptr + 1'b1;
    endfunction

    assign head_valid = count != '0;
    assign head_op = mem_op[rd_ptr];
    assign head_tag = mem_tag[rd_ptr];
    assign head_a = mem_a[rd_ptr];
    assign head_b = mem_b[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem_op[wr_ptr] <= push_op;
            mem_tag[wr_ptr] <= push_tag;
            mem_a[wr_ptr] <= push_a;
            mem_b[wr_ptr] <= push_b;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + push - pop;
            // each pop hands a slot back to the station
            credit <= pop;
        end
    end

endmodule

/* src/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,

    input  logic                                disp_valid,
    input  logic [tomasulo_pkg::op_width-1:0]   disp_op,
    input  logic                                disp_use_imm,
    input  logic [tomasulo_pkg::tag_width-1:0]  disp_tag,
    input  logic [tomasulo_pkg::tag_width-1:0]  disp_src1_tag,
    input  logic [tomasulo_pkg::data_width-1:0] disp_src1_val,
    input  logic [tomasulo_pkg::tag_width-1:0]  disp_src2_tag,
    input  logic [tomasulo_pkg::data_width-1:0] disp_src2_val,
    input  logic [tomasulo_pkg::data_width-1:0] disp_imm,
    output logic                                disp_credit,

    input  logic                                cdb_valid_0,
    input  logic [tomasulo_pkg::tag_width-1:0]  cdb_tag_0,
    input  logic [tomasulo_pkg::data_width-1:0] cdb_value_0,
    input  logic                                cdb_valid_1,
    input  logic [tomasulo_pkg::tag_width-1:0]  cdb_tag_1,
    input  logic [tomasulo_pkg::data_width-1:0] cdb_value_1,

    output logic                                issue_valid_0,
    output logic [tomasulo_pkg::op_width-1:0]   issue_op_0,
    output logic [tomasulo_pkg::tag_width-1:0]  issue_tag_0,
    output logic [tomasulo_pkg::data_width-1:0] issue_a_0,
    output logic [tomasulo_pkg::data_width-1:0] issue_b_0,
    input  logic                                iq_credit_0,

    output logic                                issue_valid_1,
    output logic [tomasulo_pkg::op_width-1:0]   issue_op_1,
    output logic [tomasulo_pkg::tag_width-1:0]  issue_tag_1,
    output logic [tomasulo_pkg::data_width-1:0] issue_a_1,
    output logic [tomasulo_pkg::data_width-1:0] issue_b_1,
    input  logic                                iq_credit_1
);
    import tomasulo_pkg::*;

    logic [rs_depth-1:0]   busy;
    logic [op_width-1:0]   ent_op       [rs_depth];
    logic [tag_width-1:0]  ent_tag      [rs_depth];
    logic [tag_width-1:0]  ent_src1_tag [rs_depth];
    logic [tag_width-1:0]  ent_src2_tag [rs_depth];
    logic [data_width-1:0] ent_a        [rs_depth];
    logic [data_width-1:0] ent_b        [rs_depth];

    logic [rs_depth-1:0]     ready;
    logic [rs_depth-1:0]     ready_1;
    logic [rs_idx_width-1:0] free_idx;
    logic [rs_idx_width-1:0] sel_0;
    logic [rs_idx_width-1:0] sel_1;

    logic [credit_width-1:0] credit_0;
    logic [credit_width-1:0] credit_1;

    // disp_credit pulses still owed, two entries can free in one cycle
    logic [rs_idx_width:0] credits_owed;
    logic [rs_idx_width:0] owed_next;

    // operands of the incoming instruction after a same-cycle broadcast
    logic [tag_width-1:0]  d_src1_tag;
    logic [tag_width-1:0]  d_src2_tag;
    logic [data_width-1:0] d_a;
    logic [data_width-1:0] d_b;

    function automatic logic cdb_hit(
        input logic                 valid,
        input logic [tag_width-1:0] bus_tag,
        input logic [tag_width-1:0] src_tag
    );
        return valid && src_tag != '0 && src_tag == bus_tag;
    endfunction

    function automatic logic [rs_idx_width-1:0] first_set(input logic [rs_depth-1:0] vec);
        logic [rs_idx_width-1:0] idx;
        idx = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = rs_idx_width'(i);
            end
        end
        return idx;
    endfunction

    always_comb begin
        d_src1_tag = disp_src1_tag;
        d_a = disp_src1_val;
        if (cdb_hit(cdb_valid_0, cdb_tag_0, disp_src1_tag)) begin
            d_src1_tag = '0;
            d_a = cdb_value_0;
        end else if (cdb_hit(cdb_valid_1, cdb_tag_1, disp_src1_tag)) begin
            d_src1_tag = '0;
            d_a = cdb_value_1;
        end

        d_src2_tag = disp_src2_tag;
        d_b = disp_src2_val;
        // immediate replaces the second source outright
        if (disp_use_imm) begin
            d_src2_tag = '0;
            d_b = disp_imm;
        end else if (cdb_hit(cdb_valid_0, cdb_tag_0, disp_src2_tag)) begin
            d_src2_tag = '0;
            d_b = cdb_value_0;
        end else if (cdb_hit(cdb_valid_1, cdb_tag_1, disp_src2_tag)) begin
            d_src2_tag = '0;
            d_b = cdb_value_1;
        end
    end

    always_comb begin
        for (int i = 0; i < rs_depth; i++) begin
            ready[i] = busy[i] && ent_src1_tag[i] == '0 && ent_src2_tag[i] == '0;
        end
    end

    // lane 0 gets the lowest ready entry, lane 1 the lowest left over
    assign free_idx = first_set(~busy);
    assign sel_0 = first_set(ready);
    assign issue_valid_0 = |ready && credit_0 != '0;
    assign ready_1 = ready & ~(rs_depth'(issue_valid_0) << sel_0);
    assign sel_1 = first_set(ready_1);
    assign issue_valid_1 = |ready_1 && credit_1 != '0;

    assign issue_op_0 = ent_op[sel_0];
    assign issue_tag_0 = ent_tag[sel_0];
    assign issue_a_0 = ent_a[sel_0];
    assign issue_b_0 = ent_b[sel_0];
    assign issue_op_1 = ent_op[sel_1];
    assign issue_tag_1 = ent_tag[sel_1];
    assign issue_a_1 = ent_a[sel_1];
    assign issue_b_1 = ent_b[sel_1];

    assign owed_next = credits_owed + (rs_idx_width + 1)'(issue_valid_0)
                     + (rs_idx_width + 1)'(issue_valid_1);

    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_depth; i++) begin
            if (disp_valid && !busy[i] && free_idx == rs_idx_width'(i)) begin
                ent_op[i] <= disp_op;
                ent_tag[i] <= disp_tag;
                ent_src1_tag[i] <= d_src1_tag;
                ent_src2_tag[i] <= d_src2_tag;
                ent_a[i] <= d_a;
                ent_b[i] <= d_b;
            end else if (busy[i]) begin
                // wakeup from either cdb lane
                if (cdb_hit(cdb_valid_0, cdb_tag_0, ent_src1_tag[i])) begin
                    ent_src1_tag[i] <= '0;
                    ent_a[i] <= cdb_value_0;
                end else if (cdb_hit(cdb_valid_1, cdb_tag_1, ent_src1_tag[i])) begin
                    ent_src1_tag[i] <= '0;
                    ent_a[i] <= cdb_value_1;
                end
                if (cdb_hit(cdb_valid_0, cdb_tag_0, ent_src2_tag[i])) begin
                    ent_src2_tag[i] <= '0;
                    ent_b[i] <= cdb_value_0;
                end else if (cdb_hit(cdb_valid_1, cdb_tag_1, ent_src2_tag[i])) begin
                    ent_src2_tag[i] <= '0;
                    ent_b[i] <= cdb_value_1;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= '0;
            credit_0 <= credit_width'(iq_depth);
            credit_1 <= credit_width'(iq_depth);
            credits_owed <= '0;
            disp_credit <= 1'b0;
        end else if (flush) begin
            // dispatcher resets its own count, so nothing is owed
            busy <= '0;
            credit_0 <= credit_width'(iq_depth);
            credit_1 <= credit_width'(iq_depth);
            credits_owed <= '0;
            disp_credit <= 1'b0;
        end else begin
            if (issue_valid_0) begin
                busy[sel_0] <= 1'b0;
            end
            if (issue_valid_1) begin
                busy[sel_1] <= 1'b0;
            end
            if (disp_valid) begin
                busy[free_idx] <= 1'b1;
            end
            credit_0 <= credit_0 - credit_width'(issue_valid_0) + credit_width'(iq_credit_0);
            credit_1 <= credit_1 - credit_width'(issue_valid_1) + credit_width'(iq_credit_1);
            // one pulse per cycle, a backlog drains on following cycles
            disp_credit <= owed_next != '0;
            credits_owed <= owed_next - (rs_idx_width + 1)'(owed_next != '0);
        end
    end

endmodule

/* src/tomasulo_pkg.sv */
package tomasulo_pkg;

    // rob tag, zero means no producer
    localparam int tag_width = 4;
    localparam int data_width = 32;
    localparam int op_width = 4;

    // station entries, also the dispatcher's starting credits
    localparam int rs_depth = 8;
    localparam int rs_idx_width = $clog2(rs_depth);

    // per-lane issue queue depth and the station's lane credit counters
    localparam int iq_depth = 2;
    localparam int credit_width = $clog2(iq_depth + 1);

    localparam int mul_cycles = 3;
    localparam int mul_cnt_width = $clog2(mul_cycles + 1);

    localparam logic [op_width-1:0] op_add = 4'd0;
    localparam logic [op_width-1:0] op_sub = 4'd1;
    localparam logic [op_width-1:0] op_and = 4'd2;
    localparam logic [op_width-1:0] op_or  = 4'd3;
    localparam logic [op_width-1:0] op_xor = 4'd4;
    localparam logic [op_width-1:0] op_sll = 4'd5;
    localparam logic [op_width-1:0] op_srl = 4'd6;
    localparam logic [op_width-1:0] op_slt = 4'd7;
    localparam logic [op_width-1:0] op_mul = 4'd8;

    // b is already the immediate or the second source
    function automatic logic [data_width-1:0] alu_result(
        input logic [op_width-1:0] op,
        input logic [data_width-1:0] a,
        input logic [data_width-1:0] b
    );
        case (op)
            op_add: return a + b;
            op_sub: return a - b;
            op_and: return a & b;
            op_or:  return a | b;
            op_xor: return a ^ b;
            op_sll: return a << b[4:0];
            op_srl: return a >> b[4:0];
            // signed compare gives 0 or 1
            op_slt: return {{(data_width - 1){1'b0}}, $signed(a) < $signed(b)};
            // low half of the product
            op_mul: return a * b;
            default: return '0;
        endcase
    endfunction

endpackage

/* tests/exec_cluster_sva.sv */
`timescale 1ns/1ps

module station_checks (
    input logic                                  clk,
    input logic                                  rst,
    input logic                                  flush,
    input logic                                  issue_valid_0,
    input logic                                  issue_valid_1,
    input logic [tomasulo_pkg::tag_width-1:0]    issue_tag_0,
    input logic [tomasulo_pkg::tag_width-1:0]    issue_tag_1,
    input logic                                  iq_credit_0,
    input logic                                  iq_credit_1,
    input logic [tomasulo_pkg::credit_width-1:0] credit_0,
    input logic [tomasulo_pkg::credit_width-1:0] credit_1,
    input logic                                  cdb_valid_0,
    input logic                                  cdb_valid_1,
    input logic [tomasulo_pkg::tag_width-1:0]    cdb_tag_0,
    input logic [tomasulo_pkg::tag_width-1:0]    cdb_tag_1
);
    import tomasulo_pkg::*;

    // queue slots taken by issues and not yet handed back by a credit pulse
    logic [credit_width:0] held_0;
    logic [credit_width:0] held_1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held_0 <= '0;
            held_1 <= '0;
        end else if (flush) begin
            held_0 <= '0;
            held_1 <= '0;
        end else begin
            held_0 <= held_0 + (credit_width + 1)'(issue_valid_0)
                    - (credit_width + 1)'(iq_credit_0);
            held_1 <= held_1 + (credit_width + 1)'(issue_valid_1)
                    - (credit_width + 1)'(iq_credit_1);
        end
    end

    credit_bound: assert property (@(posedge clk) disable iff (rst)
        credit_0 <= iq_depth && credit_1 <= iq_depth)
        else $error("lane credit count above the issue queue depth");

    // an issue into a queue with every slot held would overflow it
    issue_0_credit: assert property (@(posedge clk) disable iff (rst)
        issue_valid_0 |-> held_0 < iq_depth)
        else $error("lane 0 issued with no free queue slot");
    issue_1_credit: assert property (@(posedge clk) disable iff (rst)
        issue_valid_1 |-> held_1 < iq_depth)
        else $error("lane 1 issued with no free queue slot");

    cdb_0_tag_nonzero: assert property (@(posedge clk) disable iff (rst)
        cdb_valid_0 |-> cdb_tag_0 != '0)
        else $error("cdb lane 0 broadcast carries tag zero");
    cdb_1_tag_nonzero: assert property (@(posedge clk) disable iff (rst)
        cdb_valid_1 |-> cdb_tag_1 != '0)
        else $error("cdb lane 1 broadcast carries tag zero");

    lanes_distinct: assert property (@(posedge clk) disable iff (rst)
        issue_valid_0 && issue_valid_1 |-> issue_tag_0 != issue_tag_1)
        else $error("both lanes issued the same tag");

endmodule

bind reservation_station station_checks station_checks_i (.*);

/* tests/exec_cluster_tb.sv */
`timescale 1ns/1ps

module exec_cluster_tb;
    import tomasulo_pkg::*;

    // never dispatched as a destination, so its consumers wait forever
    localparam logic [tag_width-1:0] lost_tag = 4'd15;
    localparam logic [data_width-1:0] dummy = 32'hdead_beef;

    typedef struct packed {
        logic [op_width-1:0]   op;
        logic                  use_imm;
        logic [tag_width-1:0]  tag;
        logic [tag_width-1:0]  s1_tag;
        logic [data_width-1:0] s1_val;
        logic [tag_width-1:0]  s2_tag;
        logic [data_width-1:0] s2_val;
        logic [data_width-1:0] imm;
        logic [data_width-1:0] exp;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic                  flush;
    logic                  disp_valid;
    logic [op_width-1:0]   disp_op;
    logic                  disp_use_imm;
    logic [tag_width-1:0]  disp_tag;
    logic [tag_width-1:0]  disp_src1_tag;
    logic [data_width-1:0] disp_src1_val;
    logic [tag_width-1:0]  disp_src2_tag;
    logic [data_width-1:0] disp_src2_val;
    logic [data_width-1:0] disp_imm;
    logic                  disp_credit;
    logic                  cdb_valid_0;
    logic [tag_width-1:0]  cdb_tag_0;
    logic [data_width-1:0] cdb_value_0;
    logic                  cdb_valid_1;
    logic [tag_width-1:0]  cdb_tag_1;
    logic [data_width-1:0] cdb_value_1;

    row_t rows[$];
    // scoreboard indexed by rob tag
    logic [data_width-1:0] exp_val [16];
    bit pending [16];
    int outstanding;
    int credits;
    int pulses;
    int broadcasts;
    logic [31:0] lfsr;

    exec_cluster exec_cluster_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s at %0t ns", why, $time);
        $display("test failed");
        $fatal(1);
    endtask

    // fibonacci lfsr on x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] model_result(input logic [op_width-1:0] op,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic [63:0] prod;
        prod = {32'd0, a} * {32'd0, b};
        case (op)
            op_add: return a + b;
            op_sub: return a - b;
            op_and: return a & b;
            op_or:  return a | b;
            op_xor: return a ^ b;
            op_sll: return a << b[4:0];
            op_srl: return a >> b[4:0];
            op_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_mul: return prod[31:0];
            default: return 32'd0;
        endcase
    endfunction

    // value a source resolves to once its producer is known
    function automatic logic [31:0] operand(input logic [tag_width-1:0] tag,
                                            input logic [31:0] val);
        return tag != '0 ? exp_val[tag] : val;
    endfunction

    function automatic void add_row(input logic [op_width-1:0] op, input logic use_imm,
        input logic [tag_width-1:0] tag, input logic [tag_width-1:0] s1_tag,
        input logic [31:0] s1_val, input logic [tag_width-1:0] s2_tag,
        input logic [31:0] s2_val, input logic [31:0] imm, input logic [31:0] exp);
        row_t r;
        r = '{op, use_imm, tag, s1_tag, s1_val, s2_tag, s2_val, imm, exp};
        rows.push_back(r);
    endfunction

    task automatic record_broadcast(input string name, input logic [tag_width-1:0] tag,
                                    input logic [31:0] value);
        if (!pending[tag]) begin
            abort_run($sformatf("tag %0d broadcast with no instruction outstanding", tag));
        end
        check_value(name, value, exp_val[tag]);
        pending[tag] = 1'b0;
        outstanding--;
        broadcasts++;
    endtask

    task automatic dispatch(input row_t r);
        int wait_cycles;
        logic [tag_width-1:0] t1;
        logic [tag_width-1:0] t2;
        wait_cycles = 0;
        @(posedge clk);
        while (credits == 0 || pending[r.tag]) begin
            disp_valid <= 1'b0;
            wait_cycles++;
            if (wait_cycles > 300) begin
                abort_run("timed out waiting for a dispatch credit or a free tag");
            end
            @(posedge clk);
        end
        // in-flight sources go out by tag and the others carry the committed value
        t1 = (r.s1_tag == lost_tag || pending[r.s1_tag]) ? r.s1_tag : '0;
        t2 = (r.s2_tag == lost_tag || pending[r.s2_tag]) ? r.s2_tag : '0;
        disp_valid <= 1'b1;
        disp_op <= r.op;
        disp_use_imm <= r.use_imm;
        disp_tag <= r.tag;
        disp_src1_tag <= t1;
        disp_src1_val <= t1 != '0 ? r.s1_val : operand(r.s1_tag, r.s1_val);
        disp_src2_tag <= t2;
        disp_src2_val <= t2 != '0 ? r.s2_val : operand(r.s2_tag, r.s2_val);
        disp_imm <= r.imm;
        exp_val[r.tag] = r.exp;
        pending[r.tag] = 1'b1;
        outstanding++;
        credits--;
    endtask

    task automatic apply_rows(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            dispatch(rows[i]);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            disp_valid <= 1'b0;
        end
    endtask

    // every result broadcast and every credit back
    task automatic drain();
        int wait_cycles;
        wait_cycles = 0;
        while (outstanding != 0 || credits != rs_depth) begin
            idle_cycles(1);
            wait_cycles++;
            if (wait_cycles > 300) begin
                abort_run($sformatf("timed out with %0d results never broadcast, %0d credits",
                                    outstanding, credits));
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (disp_credit) begin
                credits++;
                pulses++;
            end
            if (cdb_valid_0) record_broadcast("cdb_value_0", cdb_tag_0, cdb_value_0);
            if (cdb_valid_1) record_broadcast("cdb_value_1", cdb_tag_1, cdb_value_1);
        end
    end

    initial begin
        int seen;
        logic [tag_width-1:0] recent [3];
        row_t r;
        lfsr = 32'h6d8c0289;
        rst = 1'b1;
        flush = 1'b0;
        disp_valid = 1'b0;
        disp_op = '0;
        disp_use_imm = 1'b0;
        disp_tag = '0;
        disp_src1_tag = '0;
        disp_src1_val = '0;
        disp_src2_tag = '0;
        disp_src2_val = '0;
        disp_imm = '0;
        credits = rs_depth;
        outstanding = 0;
        pulses = 0;
        broadcasts = 0;
        for (int t = 0; t < 16; t++) begin
            exp_val[t] = '0;
            pending[t] = 1'b0;
        end

        // rows 0..11 cover every code in register and immediate form
        add_row(op_add, 0, 1, 0, 100, 0, 23, 0, 123);
        add_row(op_sub, 0, 2, 0, 5, 0, 7, 0, 32'hffff_fffe);
        add_row(op_and, 1, 3, 0, 32'h0000_f0f0, 0, 0, 32'h0000_0ff0, 32'h0000_00f0);
        add_row(op_or, 0, 4, 0, 32'h0000_00f0, 0, 32'h0000_0f00, 0, 32'h0000_0ff0);
        add_row(op_xor, 1, 5, 0, 32'hffff_0000, 0, 0, 32'h0ff0_0ff0, 32'hf00f_0ff0);
        add_row(op_sll, 1, 6, 0, 1, 0, 0, 33, 2);
        add_row(op_srl, 0, 7, 0, 32'h8000_0000, 0, 32'h24, 0, 32'h0800_0000);
        add_row(op_slt, 0, 8, 0, 32'hffff_ffff, 0, 1, 0, 1);
        add_row(op_slt, 1, 9, 0, 5, 0, 0, 32'hffff_fffd, 0);
        add_row(op_mul, 0, 10, 0, 32'h0001_0001, 0, 32'h0001_0001, 0, 32'h0002_0001);
        add_row(op_mul, 1, 11, 0, 7, 0, 0, 6, 42);
        add_row(4'd12, 0, 12, 0, 3, 0, 4, 0, 0);
        // rows 12..17 chain through the cdb and row 16 catches tag 1 as it broadcasts
        add_row(op_add, 0, 1, 0, 10, 0, 5, 0, 15);
        add_row(op_mul, 1, 2, 1, dummy, 0, 0, 3, 45);
        add_row(op_sub, 1, 3, 2, dummy, 0, 0, 5, 40);
        add_row(op_add, 0, 4, 3, dummy, 3, dummy, 0, 80);
        add_row(op_xor, 0, 5, 4, dummy, 1, dummy, 0, 95);
        add_row(op_sll, 1, 6, 5, dummy, 0, 0, 2, 380);
        // rows 18..25 are a burst that fills both issue queues
        add_row(op_mul, 0, 1, 0, 3, 0, 4, 0, 12);
        add_row(op_mul, 0, 2, 0, 5, 0, 6, 0, 30);
        add_row(op_add, 0, 3, 0, 7, 0, 8, 0, 15);
        add_row(op_mul, 0, 4, 0, 32'h100, 0, 32'h100, 0, 32'h1_0000);
        add_row(op_mul, 1, 5, 0, 9, 0, 0, 9, 81);
        add_row(op_add, 1, 6, 0, 100, 0, 0, 200, 300);
        add_row(op_mul, 0, 7, 0, 32'hffff_ffff, 0, 2, 0, 32'hffff_fffe);
        add_row(op_mul, 0, 8, 0, 32'h1_0000, 0, 32'h1_0000, 0, 0);
        // rows 26..33 all wait behind the lost tag
        for (int i = 0; i < 8; i++) begin
            add_row(op_add, 0, tag_width'(i + 1), lost_tag, 0, 0, i, 0, i);
        end

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        apply_rows(0, 11);
        drain();
        apply_rows(12, 17);
        drain();
        pulses = 0;
        apply_rows(18, 25);
        drain();
        check_value("disp_credit pulses", pulses, 8);

        apply_rows(26, 33);
        seen = broadcasts;
        idle_cycles(20);
        check_value("cdb broadcasts", broadcasts, seen);
        check_value("dispatch credits", credits, 0);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        for (int t = 0; t < 16; t++) begin
            pending[t] = 1'b0;
        end
        outstanding = 0;
        credits = rs_depth;
        apply_rows(12, 17);
        drain();

        // random rows sourcing the last three destinations
        recent = '{default: '0};
        for (int i = 0; i < 40; i++) begin
            r.op = op_width'(lfsr_bits(4) % 10);
            r.use_imm = lfsr_bits(1);
            r.tag = tag_width'(1 + lfsr_bits(4) % 14);
            r.s1_tag = lfsr_bits(1) ? recent[lfsr_bits(2) % 3] : '0;
            r.s1_val = lfsr_bits(32);
            r.s2_tag = lfsr_bits(1) ? recent[lfsr_bits(2) % 3] : '0;
            r.s2_val = lfsr_bits(32);
            r.imm = lfsr_bits(32);
            r.exp = model_result(r.op, operand(r.s1_tag, r.s1_val),
                                 r.use_imm ? r.imm : operand(r.s2_tag, r.s2_val));
            dispatch(r);
            recent[i % 3] = r.tag;
        end
        drain();

        $display("test passed");
        $finish;
    end

endmodule
